// File: flist.f
icache_pkg.sv
icache_array_if.sv
icache_tag_store.sv
icache_data_store.sv
icache_fetch_ctrl.sv
icache_top.sv
tb_icache.sv

// File: Bender.yml
package:
  name: icache

sources:
  # design
  - icache_pkg.sv
  - icache_array_if.sv
  - icache_tag_store.sv
  - icache_data_store.sv
  - icache_fetch_ctrl.sv
  - icache_top.sv

  # testbench
  - target: simulation
    files:
      - tb_icache.sv

// File: tb_icache.sv
// instruction cache testbench with random fetches checked against memory and residency models
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
  import icache_pkg::*;

  localparam int unsigned NUM_WAYS = DEFAULT_NUM_WAYS;
  localparam int unsigned NUM_SETS = DEFAULT_NUM_SETS;
  localparam int unsigned IDX_W    = $clog2(NUM_SETS);
  localparam int unsigned WAY_W    = $clog2(NUM_WAYS);
  localparam int unsigned POOL_N   = 16;
  localparam int          N_RANDOM    = 300;
  localparam int          N_DIRECTED  = 16;
  localparam int          FETCH_BOUND = 64;
  localparam logic [31:0] SEED        = 32'h40df2b31;

  logic               clk_i;
  logic               rst_ni;
  logic               en_i;
  logic               flush_i;
  logic               req_i;
  addr_t              addr_i;
  logic               ready_o;
  logic               valid_o;
  word_t              data_o;
  logic               mem_req_o;
  addr_t              mem_addr_o;
  logic               mem_nc_o;
  logic [WAY_W-1:0]   mem_way_o;
  logic               mem_ack_i;
  logic               mem_rtrn_vld_i;
  rtn_type_e          mem_rtrn_type_i;
  line_t              mem_rtrn_data_i;
  logic [IDX_W-1:0]   mem_inv_idx_i;
  logic [WAY_W-1:0]   mem_inv_way_i;
  logic               mem_inv_all_i;
  logic               miss_o;
  logic               busy_o;

  // line address to the way reported on mem_way_o at its refill
  int    res_way [addr_t];
  bit    en_model;
  addr_t pool [POOL_N];
  int    value_errors;
  int    proto_errors;

  icache_top dut_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .req_i           (req_i),
    .addr_i          (addr_i),
    .ready_o         (ready_o),
    .valid_o         (valid_o),
    .data_o          (data_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_nc_o        (mem_nc_o),
    .mem_way_o       (mem_way_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_type_i (mem_rtrn_type_i),
    .mem_rtrn_data_i (mem_rtrn_data_i),
    .mem_inv_idx_i   (mem_inv_idx_i),
    .mem_inv_way_i   (mem_inv_way_i),
    .mem_inv_all_i   (mem_inv_all_i),
    .miss_o          (miss_o),
    .busy_o          (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // a hung run ends after the bound per operation
  initial begin
    repeat ((N_RANDOM + N_DIRECTED) * FETCH_BOUND) @(posedge clk_i);
    $display("watchdog expired, the run did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////
  // models
  ////////////////////

  // memory word is a hash of the word address
  function automatic word_t mem_word(input addr_t a);
    word_t h;
    h = word_t'(a[ADDR_WIDTH-1:2]);
    h = h * 32'h9e3779b1;
    h = h ^ (h >> 13);
    h = h ^ 32'h5bd1e995;
    return h;
  endfunction

  function automatic addr_t line_of(input addr_t a);
    return {a[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
  endfunction

  function automatic logic [IDX_W-1:0] set_of(input addr_t a);
    return a[OFFSET_WIDTH +: IDX_W];
  endfunction

  function automatic line_t make_line(input addr_t a);
    line_t l;
    for (int w = 0; w < LINE_WIDTH / FETCH_WIDTH; w++) begin
      l[w*FETCH_WIDTH +: FETCH_WIDTH] = mem_word(line_of(a) | addr_t'(w * 4));
    end
    return l;
  endfunction

  function automatic addr_t random_addr();
    return pool[$urandom_range(0, POOL_N - 1)] | addr_t'($urandom_range(0, 3) * 4);
  endfunction

  // lowest way of the set that holds no resident line, -1 when the set is full
  function automatic int free_way(input addr_t a);
    bit [NUM_WAYS-1:0] used;
    int                found;
    used  = '0;
    found = -1;
    foreach (res_way[l]) begin
      if (set_of(l) == set_of(a)) begin
        used[res_way[l]] = 1'b1;
      end
    end
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!used[w]) begin
        found = w;
      end
    end
    return found;
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("FAILED at time %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      proto_errors++;
      $display("ERROR at time %0t: %s", $time, what);
    end
  endtask

  ////////////////////
  // driver tasks
  ////////////////////

  // sweep lasts one cycle per set with ready_o low
  task automatic wait_sweep();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (busy_o) begin
      check_true(!ready_o, "ready_o high during the valid-bit sweep");
      cycles++;
      @(negedge clk_i);
    end
    check_value("sweep length", cycles, NUM_SETS);
    @(posedge clk_i);
    #1;
  endtask

  // one fetch that also plays the refill side of memory
  task automatic fetch(input addr_t addr);
    addr_t line;
    addr_t req_addr;
    addr_t evict_q [$];
    bit    exp_hit;
    bit    req_seen;
    bit    acked;
    bit    fill_sent;
    bit    done;
    int    cyc;
    int    ack_wait;
    int    fill_wait;
    int    way;
    int    exp_way;
    line      = line_of(addr);
    exp_hit   = en_model && res_way.exists(line);
    exp_way   = free_way(line);
    req_addr  = '0;
    req_seen  = 1'b0;
    acked     = 1'b0;
    fill_sent = 1'b0;
    done      = 1'b0;
    cyc       = 0;
    way       = 0;
    ack_wait  = $urandom_range(0, 3);
    fill_wait = $urandom_range(0, 4);
    req_i  = 1'b1;
    addr_i = addr;
    @(negedge clk_i);
    while (!ready_o) @(negedge clk_i);
    // accepted on this edge
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      cyc++;
      if (cyc == 1) begin
        check_true(mem_req_o == !exp_hit, "refill request does not match the expected hit or miss");
      end
      if (mem_req_o && !req_seen) begin
        req_seen = 1'b1;
        req_addr = mem_addr_o;
        way      = mem_way_o;
        check_value("mem_nc_o", mem_nc_o, !en_model);
        check_value("mem_addr_o", mem_addr_o, en_model ? line : {addr[ADDR_WIDTH-1:2], 2'b00});
        // allocation goes to the lowest way that the model holds empty
        if (en_model && exp_way >= 0) begin
          check_value("mem_way_o", mem_way_o, exp_way);
        end
      end
      // miss_o marks the ack of a cacheable refill only
      if (mem_req_o && mem_ack_i) begin
        acked = 1'b1;
        check_value("miss_o", miss_o, en_model);
      end else begin
        check_true(!miss_o, "miss_o pulsed outside a refill handshake");
      end
      if (valid_o) begin
        done = 1'b1;
        check_value("data_o", data_o, mem_word(addr));
        if (exp_hit) begin
          check_true(!req_seen && !mem_req_o && cyc == 1,
                     "resident line did not complete as a one-cycle hit");
        end else begin
          check_true(fill_sent, "valid_o for a non-resident line before its fill");
        end
      end
      @(posedge clk_i);
      #1;
      mem_ack_i      = 1'b0;
      mem_rtrn_vld_i = 1'b0;
      if (!done && req_seen && !acked) begin
        if (ack_wait == 0) mem_ack_i = 1'b1;
        else ack_wait--;
      end else if (!done && acked && !fill_sent) begin
        if (fill_wait == 0) begin
          mem_rtrn_vld_i  = 1'b1;
          mem_rtrn_type_i = RTN_IFILL;
          mem_rtrn_data_i = make_line(req_addr);
          fill_sent       = 1'b1;
        end else begin
          fill_wait--;
        end
      end
    end
    // the filled way replaces whatever the model held there
    if (en_model && !exp_hit && fill_sent) begin
      foreach (res_way[a]) begin
        if (set_of(a) == set_of(line) && res_way[a] == way) evict_q.push_back(a);
      end
      foreach (evict_q[k]) res_way.delete(evict_q[k]);
      res_way[line] = way;
    end
  endtask

  task automatic send_inv(input logic [IDX_W-1:0] idx, input logic [WAY_W-1:0] way,
                          input logic all);
    addr_t kill_q [$];
    mem_rtrn_vld_i  = 1'b1;
    mem_rtrn_type_i = RTN_INV;
    mem_inv_idx_i   = idx;
    mem_inv_way_i   = way;
    mem_inv_all_i   = all;
    @(negedge clk_i);
    check_true(!ready_o, "ready_o high while an invalidation arrives");
    @(posedge clk_i);
    #1;
    mem_rtrn_vld_i = 1'b0;
    mem_inv_all_i  = 1'b0;
    foreach (res_way[a]) begin
      if (set_of(a) == idx && (all || res_way[a] == int'(way))) kill_q.push_back(a);
    end
    foreach (kill_q[k]) res_way.delete(kill_q[k]);
  endtask

  // invalidate the way that holds this line or a random way of its set
  task automatic inv_line(input addr_t a);
    if (res_way.exists(line_of(a))) begin
      send_inv(set_of(a), WAY_W'(res_way[line_of(a)]), 1'b0);
    end else begin
      send_inv(set_of(a), WAY_W'($urandom_range(0, NUM_WAYS - 1)), 1'b0);
    end
  endtask

  task automatic flush_cache();
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    wait_sweep();
    res_way.delete();
  endtask

  // enabling starts a sweep while disabling takes effect on the next edge
  task automatic set_enable(input bit en);
    en_i = en;
    @(posedge clk_i);
    #1;
    if (en && !en_model) begin
      wait_sweep();
      res_way.delete();
    end
    en_model = en;
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    addr_t a;
    int    sel;
    value_errors    = 0;
    proto_errors    = 0;
    en_model        = 1'b1;
    rst_ni          = 1'b0;
    en_i            = 1'b1;
    flush_i         = 1'b0;
    req_i           = 1'b0;
    addr_i          = '0;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_type_i = RTN_IFILL;
    mem_rtrn_data_i = '0;
    mem_inv_idx_i   = '0;
    mem_inv_way_i   = '0;
    mem_inv_all_i   = 1'b0;
    void'($urandom(SEED));

    // four sets with four distinct tags each so no set holds more lines than ways
    for (int k = 0; k < POOL_N; k++) begin
      pool[k] = (addr_t'(16'h4000 + k) << (IDX_W + OFFSET_WIDTH)) |
                (addr_t'((k % 4) * 5) << OFFSET_WIDTH);
    end

    @(posedge clk_i);
    @(negedge clk_i);
    check_true(!ready_o && !valid_o && !mem_req_o && !miss_o, "outputs active during reset");
    check_true(busy_o, "busy_o low during reset");
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    wait_sweep();

    // miss, hits, then a single-way invalidation
    a = pool[0] | addr_t'(4);
    fetch(a);
    fetch(a);
    fetch(pool[0] | addr_t'(12));
    inv_line(a);
    fetch(a);
    fetch(pool[4]);
    // all ways of the set
    send_inv(set_of(a), '0, 1'b1);
    fetch(a);
    fetch(pool[4]);
    // non-cacheable fetches repeat their request
    set_enable(1'b0);
    fetch(a);
    fetch(a);
    set_enable(1'b1);
    fetch(a);

    for (int i = 0; i < N_RANDOM; i++) begin
      sel = $urandom_range(0, 99);
      if (sel < 5) begin
        inv_line(random_addr());
      end else if (sel < 8) begin
        send_inv(set_of(random_addr()), '0, 1'b1);
      end else if (sel < 10) begin
        flush_cache();
      end else if (sel < 13) begin
        set_enable(!en_model);
      end else begin
        fetch(random_addr());
      end
    end

    // lines miss again after a flush and hit afterwards
    set_enable(1'b1);
    fetch(a);
    flush_cache();
    fetch(a);
    fetch(a);

    $display("checks done: %0d value errors, %0d protocol errors", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: icache_top.sv
// set-associative instruction cache top level with plain fetch, refill and return ports
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int unsigned NUM_WAYS = icache_pkg::DEFAULT_NUM_WAYS,
  parameter int unsigned NUM_SETS = icache_pkg::DEFAULT_NUM_SETS
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        en_i,
  input  logic                        flush_i,
  // fetch port
  input  logic                        req_i,
  input  icache_pkg::addr_t           addr_i,
  output logic                        ready_o,
  output logic                        valid_o,
  output icache_pkg::word_t           data_o,
  // refill request
  output logic                        mem_req_o,
  output icache_pkg::addr_t           mem_addr_o,
  output logic                        mem_nc_o,
  output logic [$clog2(NUM_WAYS)-1:0] mem_way_o,
  input  logic                        mem_ack_i,
  // return port, fills and invalidations
  input  logic                        mem_rtrn_vld_i,
  input  icache_pkg::rtn_type_e       mem_rtrn_type_i,
  input  icache_pkg::line_t           mem_rtrn_data_i,
  input  logic [$clog2(NUM_SETS)-1:0] mem_inv_idx_i,
  input  logic [$clog2(NUM_WAYS)-1:0] mem_inv_way_i,
  input  logic                        mem_inv_all_i,
  // status
  output logic                        miss_o,
  output logic                        busy_o
);
  import icache_pkg::*;

  logic                      inv_en;
  logic [OFFSET_WIDTH-3:0]   offset;

  icache_array_if #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS)
  ) arr_if ();

  icache_fetch_ctrl #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS)
  ) i_fetch_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .arr             (arr_if.ctrl),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .req_i           (req_i),
    .addr_i          (addr_i),
    .ready_o         (ready_o),
    .valid_o         (valid_o),
    .data_o          (data_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_nc_o        (mem_nc_o),
    .mem_way_o       (mem_way_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_type_i (mem_rtrn_type_i),
    .mem_rtrn_data_i (mem_rtrn_data_i),
    .inv_en_o        (inv_en),
    .offset_o        (offset),
    .miss_o          (miss_o),
    .busy_o          (busy_o)
  );

  // tags and valid bits, invalidations come straight from the return port
  icache_tag_store #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS)
  ) i_tag_store (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .arr       (arr_if.tag),
    .inv_en_i  (inv_en),
    .inv_idx_i (mem_inv_idx_i),
    .inv_way_i (mem_inv_way_i),
    .inv_all_i (mem_inv_all_i)
  );

  // line data, written from the fill line
  icache_data_store #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS)
  ) i_data_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .arr         (arr_if.data),
    .fill_line_i (mem_rtrn_data_i),
    .offset_i    (offset)
  );

endmodule

`default_nettype wire

// File: icache_fetch_ctrl.sv
// fetch controller with the lookup fsm, refill request and output word selection
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_ctrl #(
  parameter int unsigned NUM_WAYS = icache_pkg::DEFAULT_NUM_WAYS,
  parameter int unsigned NUM_SETS = icache_pkg::DEFAULT_NUM_SETS
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  icache_array_if.ctrl                        arr,
  input  logic                                en_i,
  input  logic                                flush_i,
  // fetch port
  input  logic                                req_i,
  input  icache_pkg::addr_t                   addr_i,
  output logic                                ready_o,
  output logic                                valid_o,
  output icache_pkg::word_t                   data_o,
  // refill request
  output logic                                mem_req_o,
  output icache_pkg::addr_t                   mem_addr_o,
  output logic                                mem_nc_o,
  output logic [$clog2(NUM_WAYS)-1:0]         mem_way_o,
  input  logic                                mem_ack_i,
  // return port
  input  logic                                mem_rtrn_vld_i,
  input  icache_pkg::rtn_type_e               mem_rtrn_type_i,
  input  icache_pkg::line_t                   mem_rtrn_data_i,
  output logic                                inv_en_o,
  output logic [icache_pkg::OFFSET_WIDTH-3:0] offset_o,
  // status
  output logic                                miss_o,
  output logic                                busy_o
);
  import icache_pkg::*;

  localparam int unsigned IDX_W  = $clog2(NUM_SETS);
  localparam int unsigned TAG_W  = ADDR_WIDTH - IDX_W - OFFSET_WIDTH;
  localparam int unsigned WORD_W = OFFSET_WIDTH - 2;

  fetch_state_e state_d, state_q;
  logic         flush_d, flush_q;
  logic         en_d, en_q;
  logic         nc_d, nc_q;
  addr_t        addr_q;

  logic              accept;
  logic              inv_en;
  logic              fill;
  logic              hit_ok;
  logic              nc_rd;
  logic              rden;
  logic              wren;
  logic              flush_en;
  logic [WORD_W-1:0] offset_q;
  addr_t             line_addr;
  addr_t             word_addr;
  word_t             hit_word;
  word_t             fill_word;

  ////////////////////
  // return port decode
  ////////////////////

  assign inv_en   = mem_rtrn_vld_i && (mem_rtrn_type_i == RTN_INV);
  assign fill     = mem_rtrn_vld_i && (mem_rtrn_type_i == RTN_IFILL);
  assign inv_en_o = inv_en;

  // address split
  assign accept    = ready_o & req_i;
  assign offset_q  = addr_q[OFFSET_WIDTH-1:2];
  assign offset_o  = offset_q;
  assign arr.index = accept ? addr_i[OFFSET_WIDTH +: IDX_W] : addr_q[OFFSET_WIDTH +: IDX_W];
  assign arr.wtag  = addr_q[ADDR_WIDTH-1 -: TAG_W];

  // bypass when disabled, or when an invalidation may have made the read stale
  assign nc_rd  = ~en_q | inv_en;
  assign hit_ok = (|arr.hit) & en_q & ~inv_en;

  ////////////////////
  // fsm
  ////////////////////

  always_comb begin
    state_d   = state_q;
    // disabling takes effect at once, enabling only through a sweep
    en_d      = en_q & en_i;
    flush_d   = flush_q | flush_i;
    nc_d      = nc_q;
    ready_o   = 1'b0;
    valid_o   = 1'b0;
    mem_req_o = 1'b0;
    miss_o    = 1'b0;
    rden      = 1'b0;
    wren      = 1'b0;
    flush_en  = 1'b0;

    unique case (state_q)
      // clear every valid bit, one set per cycle
      FLUSH: begin
        flush_en = 1'b1;
        if (arr.flush_done) begin
          state_d = IDLE;
          flush_d = 1'b0;
          en_d    = en_i;
        end
      end
      IDLE: begin
        if (flush_d || (en_i && !en_q)) begin
          state_d = FLUSH;
        end else begin
          // no lookup while an invalidation writes the valid bits
          ready_o = ~mem_rtrn_vld_i;
        end
      end
      // compare cycle
      READ: begin
        if (hit_ok) begin
          valid_o = 1'b1;
          state_d = IDLE;
          // back-to-back hits
          ready_o = ~mem_rtrn_vld_i & ~flush_d;
        end else begin
          mem_req_o = 1'b1;
          nc_d      = nc_rd;
          state_d   = MISS;
          if (mem_ack_i) begin
            miss_o  = ~nc_rd;
            state_d = WAIT_FILL;
          end
        end
      end
      // hold the request until acked
      MISS: begin
        mem_req_o = 1'b1;
        if (mem_ack_i) begin
          miss_o  = ~nc_q;
          state_d = WAIT_FILL;
        end
      end
      // the fill must be consumed, a pending flush waits for it
      WAIT_FILL: begin
        if (fill) begin
          valid_o = 1'b1;
          wren    = ~nc_q;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase

    if (ready_o && req_i) begin
      rden    = 1'b1;
      state_d = READ;
    end
  end

  assign arr.rden     = rden;
  assign arr.wren     = wren;
  assign arr.flush_en = flush_en;
  assign busy_o       = (state_q != IDLE);

  ////////////////////
  // refill request
  ////////////////////

  assign line_addr  = {addr_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
  assign word_addr  = {addr_q[ADDR_WIDTH-1:2], 2'b00};
  assign mem_nc_o   = (state_q == READ) ? nc_rd : nc_q;
  assign mem_addr_o = mem_nc_o ? word_addr : line_addr;
  assign mem_way_o  = arr.repl_idx;

  // output word, and-or over the one-hot hit vector
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_word = hit_word | ({FETCH_WIDTH{arr.hit[w]}} & arr.way_words[w]);
    end
  end

  assign fill_word = mem_rtrn_data_i[offset_q*FETCH_WIDTH +: FETCH_WIDTH];
  assign data_o    = (state_q == READ) ? hit_word : fill_word;

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FLUSH;
      flush_q <= 1'b0;
      en_q    <= 1'b0;
      nc_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      flush_q <= flush_d;
      en_q    <= en_d;
      nc_q    <= nc_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= addr_i;
    end
  end

  legal_state_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {FLUSH, IDLE, READ, MISS, WAIT_FILL})
    else $error("fetch ctrl: illegal state");

  req_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_addr_o)))
    else $error("fetch ctrl: refill request dropped or changed before ack");

endmodule

`default_nettype wire

// File: icache_data_store.sv
// data store with one line array per way and word selection per way
`timescale 1ns/1ps
`default_nettype none

module icache_data_store #(
  parameter int unsigned NUM_WAYS = icache_pkg::DEFAULT_NUM_WAYS,
  parameter int unsigned NUM_SETS = icache_pkg::DEFAULT_NUM_SETS
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  icache_array_if.data                        arr,
  input  icache_pkg::line_t                   fill_line_i,
  input  logic [icache_pkg::OFFSET_WIDTH-3:0] offset_i
);
  import icache_pkg::*;

  line_t                line_mem [NUM_SETS][NUM_WAYS];
  line_t [NUM_WAYS-1:0] line_rd;
  word_t [NUM_WAYS-1:0] words;

  // refill writes the whole line into the allocated way
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (arr.wren && arr.repl_oh[w]) begin
        line_mem[arr.index][w] <= fill_line_i;
      end
    end
  end

  // all ways read side by side with the tag store
  // cleared at reset so way_words never carries X into the output mux
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_rd <= '0;
    end else if (arr.rden) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        line_rd[w] <= line_mem[arr.index][w];
      end
    end
  end

  // word at the latched offset
  // ready in the compare cycle
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      words[w] = line_rd[w][offset_i*FETCH_WIDTH +: FETCH_WIDTH];
    end
  end

  assign arr.way_words = words;

endmodule

`default_nettype wire

// File: icache_tag_store.sv
// tag and valid arrays with hit compare, flush sweep, invalidation and way replacement
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store #(
  parameter int unsigned NUM_WAYS = icache_pkg::DEFAULT_NUM_WAYS,
  parameter int unsigned NUM_SETS = icache_pkg::DEFAULT_NUM_SETS
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  icache_array_if.tag                 arr,
  input  logic                        inv_en_i,
  input  logic [$clog2(NUM_SETS)-1:0] inv_idx_i,
  input  logic [$clog2(NUM_WAYS)-1:0] inv_way_i,
  input  logic                        inv_all_i
);
  import icache_pkg::*;

  localparam int unsigned IDX_W = $clog2(NUM_SETS);
  localparam int unsigned WAY_W = $clog2(NUM_WAYS);
  localparam int unsigned TAG_W = ADDR_WIDTH - IDX_W - OFFSET_WIDTH;

  typedef logic [TAG_W-1:0] tag_t;

  tag_t                tag_mem [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0] vld_mem [NUM_SETS];

  // registered read-out of one set
  tag_t [NUM_WAYS-1:0] tag_rd;
  logic [NUM_WAYS-1:0] vld_rd;
  logic [NUM_WAYS-1:0] hit;

  logic [IDX_W-1:0]    arr_addr;
  logic [IDX_W-1:0]    flush_cnt_q;
  logic [WAY_W-1:0]    inv_way;
  logic [WAY_W-1:0]    rnd_way;
  logic                all_valid;
  logic [7:0]          lfsr_q;

  ////////////////////
  // sweep and lfsr
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_cnt_q <= '0;
      lfsr_q      <= 8'hff;
    end else begin
      // one set per cycle, wraps to zero at the end of the sweep
      if (arr.flush_en) begin
        flush_cnt_q <= arr.flush_done ? '0 : flush_cnt_q + 1'b1;
      end
      // taps 8,6,5,4
      if (arr.wren) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      end
    end
  end

  assign arr.flush_done = (flush_cnt_q == IDX_W'(NUM_SETS - 1));

  // flush wins over invalidation, invalidation over lookup
  assign arr_addr = arr.flush_en ? flush_cnt_q :
                    inv_en_i     ? inv_idx_i   :
                                   arr.index;

  ////////////////////
  // arrays
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (arr.flush_en) begin
      vld_mem[arr_addr] <= '0;
    end else if (inv_en_i) begin
      if (inv_all_i) begin
        vld_mem[arr_addr] <= '0;
      end else begin
        vld_mem[arr_addr][inv_way_i] <= 1'b0;
      end
    end else if (arr.wren) begin
      // fill goes into the way chosen at lookup
      vld_mem[arr_addr][arr.repl_idx] <= 1'b1;
      tag_mem[arr_addr][arr.repl_idx] <= arr.wtag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (arr.rden) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        tag_rd[w] <= tag_mem[arr_addr][w];
      end
    end
  end

  // valid read-out starts cleared so replacement is defined before a lookup
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_rd <= '0;
    end else if (arr.rden) begin
      vld_rd <= vld_mem[arr_addr];
    end
  end

  ////////////////////
  // compare and replacement
  ////////////////////

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit[w] = vld_rd[w] & (tag_rd[w] == arr.wtag);
    end
  end

  assign arr.hit = hit;

  // lowest invalid way
  always_comb begin
    inv_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!vld_rd[w]) begin
        inv_way = WAY_W'(w);
      end
    end
  end

  assign all_valid    = &vld_rd;
  assign rnd_way      = lfsr_q[WAY_W-1:0];
  assign arr.repl_idx = all_valid ? rnd_way : inv_way;
  assign arr.repl_oh  = NUM_WAYS'(1) << arr.repl_idx;

  // a tag is resident in at most one way of a set
  hit_onehot_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    arr.rden |=> $onehot0(arr.hit))
    else $error("tag store: more than one way hits");

  // fill and invalidation share the return port
  fill_vs_inv_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(arr.wren && inv_en_i))
    else $error("tag store: fill and invalidation in one cycle");

endmodule

`default_nettype wire

// File: icache_array_if.sv
// array access interface between the fetch controller and the tag and data stores
`timescale 1ns/1ps
`default_nettype none

interface icache_array_if #(
  parameter int unsigned NUM_WAYS = icache_pkg::DEFAULT_NUM_WAYS,
  parameter int unsigned NUM_SETS = icache_pkg::DEFAULT_NUM_SETS
);
  import icache_pkg::*;

  localparam int unsigned IDX_W = $clog2(NUM_SETS);
  localparam int unsigned WAY_W = $clog2(NUM_WAYS);
  localparam int unsigned TAG_W = ADDR_WIDTH - IDX_W - OFFSET_WIDTH;

  // set access, shared by both stores
  logic [IDX_W-1:0]     index;
  logic                 rden;
  logic                 wren;
  // latched fetch tag, compared and written
  logic [TAG_W-1:0]     wtag;
  logic                 flush_en;

  // lookup results, valid the cycle after rden
  logic [NUM_WAYS-1:0]  hit;
  logic [NUM_WAYS-1:0]  repl_oh;
  logic [WAY_W-1:0]     repl_idx;
  logic                 flush_done;
  word_t [NUM_WAYS-1:0] way_words;

  modport ctrl (
    output index, rden, wren, wtag, flush_en,
    input  hit, repl_oh, repl_idx, flush_done, way_words
  );

  modport tag (
    input  index, rden, wren, wtag, flush_en,
    output hit, repl_oh, repl_idx, flush_done
  );

  modport data (
    input  index, rden, wren, repl_oh,
    output way_words
  );

endinterface

`default_nettype wire

// File: icache_pkg.sv
// instruction cache package with widths, vector types, message and state encodings
`default_nettype none

package icache_pkg;

  ////////////////////
  // widths
  ////////////////////

  // physical fetch address
  localparam int unsigned ADDR_WIDTH = 32;
  // one refill line, 16 bytes
  localparam int unsigned LINE_WIDTH = 128;
  // one instruction word
  localparam int unsigned FETCH_WIDTH = 32;
  // byte offset bits within a line
  localparam int unsigned OFFSET_WIDTH = 4;

  // default geometry, overridden from the top level
  localparam int unsigned DEFAULT_NUM_WAYS = 4;
  localparam int unsigned DEFAULT_NUM_SETS = 16;

  ////////////////////
  // types
  ////////////////////

  typedef logic [ADDR_WIDTH-1:0]  addr_t;
  typedef logic [LINE_WIDTH-1:0]  line_t;
  typedef logic [FETCH_WIDTH-1:0] word_t;

  // kind of message on the return port
  typedef enum logic {
    RTN_IFILL,
    RTN_INV
  } rtn_type_e;

  // fetch controller states
  typedef enum logic [2:0] {
    FLUSH,
    IDLE,
    READ,
    MISS,
    WAIT_FILL
  } fetch_state_e;

endpackage

`default_nettype wire
